//--- verilog.f
src/l0_cfg_pkg.sv
src/rv_fetch_pkg.sv
src/l0_tag_array.sv
src/l0_data_array.sv
src/l0_predecode.sv
src/l0_ctrl.sv
src/l0_icache_top.sv
verification/tb_mem_model.sv
verification/tb_l0_icache.sv

//--- verification/tb_l0_icache.sv
// Testbench for the level-0 instruction cache
// Checks fetch data, refill addresses, eviction, prefetch targets,
// flush and refill back-pressure against reference functions

module tb_l0_icache import l0_cfg_pkg::*; ();

  localparam int TIMEOUT = 200;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               flush;
  logic               prefetch_en;
  logic [ADDR_W-1:0]  fetch_addr;
  logic               fetch_valid;
  logic [FETCH_W-1:0] fetch_data;
  logic               fetch_ready;
  logic [ADDR_W-1:0]  req_addr;
  logic               req_valid;
  logic               req_ready;
  logic [LINE_W-1:0]  rsp_data;
  logic               rsp_valid;
  logic               mem_stall;
  logic [ADDR_W-1:0]  req_q [$];
  int                 rsp_count = 0;
  string              test_name = "reset";

  always #4 clk = ~clk;

  l0_icache_top DUT (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .flush_i            (flush),
    .prefetch_en_i      (prefetch_en),
    .fetch_addr_i       (fetch_addr),
    .fetch_valid_i      (fetch_valid),
    .fetch_data_o       (fetch_data),
    .fetch_ready_o      (fetch_ready),
    .refill_req_addr_o  (req_addr),
    .refill_req_valid_o (req_valid),
    .refill_req_ready_i (req_ready),
    .refill_rsp_data_i  (rsp_data),
    .refill_rsp_valid_i (rsp_valid)
  );

  tb_mem_model u_mem (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .stall_i     (mem_stall),
    .req_addr_i  (req_addr),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_data_o  (rsp_data),
    .rsp_valid_o (rsp_valid)
  );

  // --------------------------------------------------------------------------
  // Reference model and reporting
  // --------------------------------------------------------------------------
  function automatic logic [ADDR_W-1:0] line_of(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  endfunction

  function automatic logic [FETCH_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
    return u_mem.image[addr[9:2]];
  endfunction

  // Backward branches and all jumps at or after the fetch slot count as taken
  function automatic logic [ADDR_W-1:0] ref_pf_addr(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] pc;
    logic [31:0]       w;
    for (int i = int'(addr[3:2]); i < FETCH_PKTS; i++) begin
      pc = line_of(addr) + ADDR_W'(4 * i);
      w  = ref_word(pc);
      if (w[6:0] == 7'h63 && w[31]) begin
        return line_of(pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0});
      end
      if (w[6:0] == 7'h6f) begin
        return line_of(pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0});
      end
    end
    return line_of(addr) + ADDR_W'(16);
  endfunction

  task automatic abort(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // --------------------------------------------------------------------------
  // Monitors
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n && req_valid && req_ready) begin
      req_q.push_back(req_addr);
    end
    if (rst_n && rsp_valid) begin
      rsp_count++;
    end
  end

  // Every accepted fetch returns the image word of its address
  always @(negedge clk) begin
    if (rst_n && fetch_valid && fetch_ready) begin
      check(test_name, ref_word(fetch_addr), fetch_data);
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------------------------------
  task automatic fetch(input logic [ADDR_W-1:0] addr, output int new_reqs);
    int n0;
    int waited;
    n0          = req_q.size();
    fetch_addr  = addr;
    fetch_valid = 1'b1;
    waited      = 0;
    @(negedge clk);
    while (!fetch_ready) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort($sformatf("Fetch at %h in %s never completed", addr, test_name));
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    fetch_valid = 1'b0;
    new_reqs    = req_q.size() - n0;
    // A line that needed no refill answers in its first cycle
    if (new_reqs == 0) begin
      check({test_name, " hit latency"}, 0, waited);
    end
    // Without prefetching the only request is the demand refill
    if (!prefetch_en && new_reqs != 0) begin
      check({test_name, " refill address"}, line_of(addr), req_q[$]);
    end
  endtask

  task automatic wait_request(input int count);
    int waited;
    waited = 0;
    @(negedge clk);
    while (req_q.size() < count) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort($sformatf("No refill request seen in %s", test_name));
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while (req_valid || req_q.size() != rsp_count) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort($sformatf("Refill never completed in %s", test_name));
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic flush_cache();
    wait_idle();
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    int                n;
    int                n0;
    logic [31:0]       w;
    logic [ADDR_W-1:0] exp_pf;
    logic [ADDR_W-1:0] pf_cases [5];
    rst_n       = 1'b0;
    flush       = 1'b0;
    prefetch_en = 1'b0;
    fetch_addr  = '0;
    fetch_valid = 1'b0;
    mem_stall   = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_name = "sequential fetch";
    for (int i = 0; i < 64; i++) begin
      fetch(ADDR_W'(4 * i), n);
    end
    test_name = "random fetch";
    for (int i = 0; i < 48; i++) begin
      w = ref_word(ADDR_W'(32'h200 + 4 * i));
      fetch({22'd0, w[7:0], 2'b00}, n);
    end

    test_name = "refill address";
    flush_cache();
    fetch(32'h0000_0234, n);
    check("refill count on miss", 1, n);
    fetch(32'h0000_0238, n);
    check("refill count on refetch", 0, n);

    // Five lines through four ways push the first one out again
    test_name = "eviction";
    flush_cache();
    for (int i = 0; i < 5; i++) begin
      fetch(ADDR_W'(32'h300 + 16 * i), n);
    end
    fetch(32'h0000_0300, n);
    check("refill count after eviction", 1, n);

    test_name = "flush";
    fetch(32'h0000_0340, n);
    check("refill count before flush", 0, n);
    flush_cache();
    fetch(32'h0000_0340, n);
    check("refill count after flush", 1, n);

    test_name   = "prefetch";
    prefetch_en = 1'b1;
    pf_cases    = '{32'h084, 32'h0c0, 32'h100, 32'h148, 32'h180};
    foreach (pf_cases[i]) begin
      flush_cache();
      fetch(pf_cases[i], n);
      check("prefetch demand count", 1, n);
      exp_pf = ref_pf_addr(pf_cases[i]);
      // A target inside the fetched line is already cached
      if (line_of(exp_pf) != line_of(pf_cases[i])) begin
        n0 = req_q.size();
        wait_request(n0 + 1);
        check("prefetch address", exp_pf, req_q[n0]);
      end
    end
    prefetch_en = 1'b0;

    test_name = "back-pressure";
    flush_cache();
    mem_stall = 1'b1;
    @(posedge clk);
    #1;
    fetch_addr  = 32'h0000_0158;
    fetch_valid = 1'b1;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check("held request valid", 1, req_valid);
      check("held request address", 32'h0000_0150, req_addr);
    end
    @(posedge clk);
    #1;
    mem_stall = 1'b0;
    fetch(32'h0000_0158, n);
    check("refill count under back-pressure", 1, n);
    fetch(32'h0000_015c, n);
    wait_idle();

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- verification/tb_mem_model.sv
// Backing memory model for the level-0 cache testbench
// Holds a seeded instruction image and answers one refill at a time
// after a random delay, with random back-pressure on requests

module tb_mem_model import l0_cfg_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              stall_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output logic [LINE_W-1:0] rsp_data_o,
  output logic              rsp_valid_o
);

  // Higher address bits alias onto the 1 KiB image
  logic [31:0]       image [256];
  logic [31:0]       rng;
  logic [ADDR_W-1:0] line_addr;
  logic              busy;
  logic              accepted;
  logic              stall;
  int                delay;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  // Conditional branch with a byte offset
  function automatic logic [31:0] enc_branch(input logic [12:0] off);
    return {off[12], off[10:5], 5'd1, 5'd2, 3'b001, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
  endfunction

  function automatic logic [LINE_W-1:0] line_data(input logic [ADDR_W-1:0] addr);
    logic [LINE_W-1:0] line;
    for (int i = 0; i < FETCH_PKTS; i++) begin
      line[i*FETCH_W +: FETCH_W] = image[{addr[9:4], 2'(i)}];
    end
    return line;
  endfunction

  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    busy        = 1'b0;
    delay       = 0;
    rng         = 32'hf1a8eb4a;
    for (int i = 0; i < 256; i++) begin
      rng      = xorshift32(rng);
      image[i] = rng;
    end
    // Loop back edge at 0x088 into line 0x040
    image[8'h22] = enc_branch(-13'sd64);
    // Jump at 0x0c4 to 0x1c4
    image[8'h31] = enc_jal(21'h100);
    // Forward branch at 0x100 that is predicted not taken
    image[8'h40] = enc_branch(13'h020);
    // Backward jump at 0x14c into line 0x0c0
    image[8'h53] = enc_jal(-21'sd128);
    // Short loop at 0x184 that stays in its own line
    image[8'h61] = enc_branch(-13'sd4);

    forever begin
      @(posedge clk_i);
      accepted = rst_ni && req_valid_i && req_ready_o;
      stall    = stall_i;
      if (accepted) begin
        line_addr = req_addr_i;
      end
      #1;
      rng         = xorshift32(rng);
      rsp_valid_o = 1'b0;
      if (busy) begin
        delay--;
        if (delay == 0) begin
          busy        = 1'b0;
          rsp_valid_o = 1'b1;
          rsp_data_o  = line_data(line_addr);
        end
      end
      if (accepted) begin
        busy  = 1'b1;
        delay = 1 + int'(rng[7:0] % 6);
      end
      // Ready about three cycles out of four while idle
      req_ready_o = rst_ni && !busy && !stall && (rng[9:8] != 2'b00);
    end
  end

endmodule

//--- src/l0_icache_top.sv
// Level-0 instruction cache
// Small fully associative cache in front of a fetch port, with line
// refills and a branch-aware next-line prefetcher

module l0_icache_top import l0_cfg_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              prefetch_en_i,
  input  logic [ADDR_W-1:0] fetch_addr_i,
  input  logic              fetch_valid_i,
  output logic [FETCH_W-1:0] fetch_data_o,
  output logic              fetch_ready_o,
  output logic [ADDR_W-1:0] refill_req_addr_o,
  output logic              refill_req_valid_o,
  input  logic              refill_req_ready_i,
  input  logic [LINE_W-1:0] refill_rsp_data_i,
  input  logic              refill_rsp_valid_i
);

  logic [LINE_COUNT-1:0] hit;
  logic                  hit_any;
  logic                  pf_hit;
  logic [ADDR_W-1:0]     pf_addr;
  logic [LINE_COUNT-1:0] evict_strb;
  logic [TAG_W-1:0]      evict_tag;
  logic [LINE_COUNT-1:0] validate_strb;
  logic [LINE_W-1:0]     hit_line;

  l0_ctrl i_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_addr_i       (fetch_addr_i),
    .fetch_valid_i      (fetch_valid_i),
    .prefetch_en_i      (prefetch_en_i),
    .hit_any_i          (hit_any),
    .pf_hit_i           (pf_hit),
    .pf_addr_i          (pf_addr),
    .refill_req_ready_i (refill_req_ready_i),
    .refill_rsp_valid_i (refill_rsp_valid_i),
    .fetch_ready_o      (fetch_ready_o),
    .evict_strb_o       (evict_strb),
    .evict_tag_o        (evict_tag),
    .validate_strb_o    (validate_strb),
    .refill_req_addr_o  (refill_req_addr_o),
    .refill_req_valid_o (refill_req_valid_o)
  );

  l0_tag_array i_tag_array (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lookup_addr_i   (fetch_addr_i),
    .pf_addr_i       (pf_addr),
    .evict_strb_i    (evict_strb),
    .evict_tag_i     (evict_tag),
    .validate_strb_i (validate_strb),
    .flush_i         (flush_i),
    .hit_o           (hit),
    .hit_any_o       (hit_any),
    .pf_hit_o        (pf_hit)
  );

  l0_data_array i_data_array (
    .clk_i           (clk_i),
    .validate_strb_i (validate_strb),
    .rsp_data_i      (refill_rsp_data_i),
    .hit_i           (hit),
    .word_sel_i      (fetch_addr_i[LINE_ALIGN-1:2]),
    .line_o          (hit_line),
    .word_o          (fetch_data_o)
  );

  l0_predecode i_predecode (
    .fetch_addr_i (fetch_addr_i),
    .line_i       (hit_line),
    .pf_addr_o    (pf_addr)
  );

endmodule

//--- src/l0_ctrl.sv
// Level-0 cache control
// Miss detection, prefetch latching, round-robin replacement and the
// single outstanding refill, with demand requests ahead of prefetches

module l0_ctrl import l0_cfg_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [ADDR_W-1:0]     fetch_addr_i,
  input  logic                  fetch_valid_i,
  input  logic                  prefetch_en_i,
  input  logic                  hit_any_i,
  input  logic                  pf_hit_i,
  input  logic [ADDR_W-1:0]     pf_addr_i,
  input  logic                  refill_req_ready_i,
  input  logic                  refill_rsp_valid_i,
  output logic                  fetch_ready_o,
  output logic [LINE_COUNT-1:0] evict_strb_o,
  output logic [TAG_W-1:0]      evict_tag_o,
  output logic [LINE_COUNT-1:0] validate_strb_o,
  output logic [ADDR_W-1:0]     refill_req_addr_o,
  output logic                  refill_req_valid_o
);

  logic                  miss;
  logic                  miss_q;
  logic                  evict_miss;
  logic                  latch_pf;
  logic                  evict;
  logic                  pending_q;
  logic [LINE_COUNT-1:0] pending_line_q;
  logic [IDX_W-1:0]      rr_q;
  logic                  pf_vld_q;
  logic [ADDR_W-1:0]     pf_addr_q;
  logic [ADDR_W-1:0]     demand_addr;
  logic                  demand_acc;
  logic                  pf_acc;

  assign fetch_ready_o = hit_any_i;

  // --------------------------------------------------------------------------
  // Miss and prefetch detection
  // --------------------------------------------------------------------------
  assign miss       = fetch_valid_i && !hit_any_i && !pending_q;
  assign evict_miss = miss && !miss_q;

  // A new target is only taken while the refill slot is free
  assign latch_pf = prefetch_en_i && fetch_valid_i && hit_any_i && !pf_hit_i && !pending_q;

  // --------------------------------------------------------------------------
  // Replacement
  // --------------------------------------------------------------------------
  assign evict        = evict_miss || latch_pf;
  assign evict_strb_o = evict ? (LINE_COUNT'(1) << rr_q) : '0;
  assign evict_tag_o  = latch_pf ? pf_addr_i[ADDR_W-1:LINE_ALIGN]
                                 : fetch_addr_i[ADDR_W-1:LINE_ALIGN];

  assign validate_strb_o = (refill_rsp_valid_i && pending_q) ? pending_line_q : '0;

  // --------------------------------------------------------------------------
  // Request arbitration
  // --------------------------------------------------------------------------
  assign demand_addr        = {fetch_addr_i[ADDR_W-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  assign refill_req_valid_o = miss || pf_vld_q;
  assign refill_req_addr_o  = miss ? demand_addr : pf_addr_q;
  assign demand_acc         = miss && refill_req_ready_i;
  assign pf_acc             = pf_vld_q && !miss && refill_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_q         <= 1'b0;
      rr_q           <= '0;
      pending_line_q <= '0;
      pending_q      <= 1'b0;
      pf_vld_q       <= 1'b0;
    end else begin
      miss_q <= miss;
      if (evict) begin
        rr_q           <= rr_q + 1'b1;
        pending_line_q <= evict_strb_o;
      end
      // Prefetch holds the slot from the moment it is latched
      if (pending_q) begin
        if (refill_rsp_valid_i) begin
          pending_q <= 1'b0;
        end
      end else if (demand_acc || latch_pf) begin
        pending_q <= 1'b1;
      end
      if (latch_pf) begin
        pf_vld_q <= 1'b1;
      end else if (pf_acc) begin
        pf_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch_pf) begin
      pf_addr_q <= pf_addr_i;
    end
  end

  // Relies on the core holding its fetch address while stalled
  req_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_req_valid_o && !refill_req_ready_i |=>
      refill_req_valid_o && $stable(refill_req_addr_o));

  // A refill response only comes back while a refill is outstanding
  rsp_pending_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_rsp_valid_i |-> pending_q);

endmodule

//--- src/l0_predecode.sv
// Prefetch address predictor
// Scans the hit line from the fetch slot onward, predicts backward
// branches and all JAL as taken and returns the line the fetch stream
// will probably need next

module l0_predecode import l0_cfg_pkg::*; import rv_fetch_pkg::*; (
  input  logic [ADDR_W-1:0] fetch_addr_i,
  input  logic [LINE_W-1:0] line_i,
  output logic [ADDR_W-1:0] pf_addr_o
);

  instr_u [FETCH_PKTS-1:0] instr;
  logic [FETCH_PKTS-1:0]   is_branch;
  logic [FETCH_PKTS-1:0]   is_jal;
  logic [FETCH_PKTS-1:0]   taken_mask;
  logic [LINE_ALIGN-3:0]   word_off;
  logic [LINE_ALIGN-3:0]   taken_idx;
  logic                    found;
  logic [ADDR_W-1:0]       line_base;
  logic [ADDR_W-1:0]       instr_addr;
  logic [ADDR_W-1:0]       target;

  assign instr     = line_i;
  assign word_off  = fetch_addr_i[LINE_ALIGN-1:2];
  assign line_base = {fetch_addr_i[ADDR_W-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};

  // --------------------------------------------------------------------------
  // Static prediction per slot
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < FETCH_PKTS; i++) begin : gen_slot
    // A negative offset marks a loop back edge that is predicted taken
    assign is_branch[i] = (instr[i].sb.opcode == OPC_BRANCH) && instr[i].sb.imm12;
    assign is_jal[i]    = (instr[i].uj.opcode == OPC_JAL);
  end

  // Slots before the fetch word are never executed from here
  assign taken_mask = (is_branch | is_jal) & ({FETCH_PKTS{1'b1}} << word_off);

  // --------------------------------------------------------------------------
  // First taken slot
  // --------------------------------------------------------------------------
  always_comb begin
    found     = 1'b0;
    taken_idx = '0;
    // Walk downwards so the lowest set slot is left over
    for (int i = FETCH_PKTS - 1; i >= 0; i--) begin
      if (taken_mask[i]) begin
        found     = 1'b1;
        taken_idx = (LINE_ALIGN - 2)'(i);
      end
    end
  end

  assign instr_addr = {fetch_addr_i[ADDR_W-1:LINE_ALIGN], taken_idx, 2'b00};

  // --------------------------------------------------------------------------
  // Target
  // --------------------------------------------------------------------------
  always_comb begin
    if (!found) begin
      // Fall through into the next sequential line
      target = line_base + (ADDR_W'(1) << LINE_ALIGN);
    end else if (is_jal[taken_idx]) begin
      target = instr_addr + uj_imm(instr[taken_idx]);
    end else begin
      target = instr_addr + sb_imm(instr[taken_idx]);
    end
  end

  assign pf_addr_o = {target[ADDR_W-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};

endmodule

//--- src/l0_data_array.sv
// Level-0 cache line storage
// Captures refill lines and returns the hitting line and fetch word

module l0_data_array import l0_cfg_pkg::*; (
  input  logic                  clk_i,
  input  logic [LINE_COUNT-1:0] validate_strb_i,
  input  logic [LINE_W-1:0]     rsp_data_i,
  input  logic [LINE_COUNT-1:0] hit_i,
  input  logic [LINE_ALIGN-3:0] word_sel_i,
  output logic [LINE_W-1:0]     line_o,
  output logic [FETCH_W-1:0]    word_o
);

  logic [LINE_COUNT-1:0][LINE_W-1:0]  data_q;
  logic [FETCH_PKTS-1:0][FETCH_W-1:0] words;

  for (genvar i = 0; i < LINE_COUNT; i++) begin : gen_line
    always_ff @(posedge clk_i) begin
      if (validate_strb_i[i]) begin
        data_q[i] <= rsp_data_i;
      end
    end
  end

  // Hit vector is one-hot, so an AND-OR mux is enough
  always_comb begin
    line_o = '0;
    for (int i = 0; i < LINE_COUNT; i++) begin
      line_o |= {LINE_W{hit_i[i]}} & data_q[i];
    end
  end

  // Word offset picks the instruction slot
  assign words  = line_o;
  assign word_o = words[word_sel_i];

  // Each refill response fills exactly one line
  validate_onehot_a : assert property (@(posedge clk_i)
    $onehot0(validate_strb_i));

endmodule

//--- src/l0_tag_array.sv
// Level-0 cache tag store
// One tag and valid bit per line, with a full tag compare for the fetch
// address and for the predicted prefetch address

module l0_tag_array import l0_cfg_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [ADDR_W-1:0]     lookup_addr_i,
  input  logic [ADDR_W-1:0]     pf_addr_i,
  input  logic [LINE_COUNT-1:0] evict_strb_i,
  input  logic [TAG_W-1:0]      evict_tag_i,
  input  logic [LINE_COUNT-1:0] validate_strb_i,
  input  logic                  flush_i,
  output logic [LINE_COUNT-1:0] hit_o,
  output logic                  hit_any_o,
  output logic                  pf_hit_o
);

  logic [TAG_W-1:0]                 lookup_tag;
  logic [TAG_W-1:0]                 pf_tag;
  logic [LINE_COUNT-1:0][TAG_W-1:0] tag_q;
  logic [LINE_COUNT-1:0]            valid_q;
  logic [LINE_COUNT-1:0]            pf_hit;

  assign lookup_tag = lookup_addr_i[ADDR_W-1:LINE_ALIGN];
  assign pf_tag     = pf_addr_i[ADDR_W-1:LINE_ALIGN];

  // --------------------------------------------------------------------------
  // Compare
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < LINE_COUNT; i++) begin : gen_cmp
    assign hit_o[i]  = valid_q[i] && (tag_q[i] == lookup_tag);
    assign pf_hit[i] = valid_q[i] && (tag_q[i] == pf_tag);
  end

  assign hit_any_o = |hit_o;
  assign pf_hit_o  = |pf_hit;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  // New tag goes in when a line is claimed for a refill
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < LINE_COUNT; i++) begin
      if (evict_strb_i[i]) begin
        tag_q[i] <= evict_tag_i;
      end
    end
  end

  // A refill that lands together with a flush still fills its line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < LINE_COUNT; i++) begin
        if (flush_i || evict_strb_i[i]) begin
          valid_q[i] <= 1'b0;
        end
        if (validate_strb_i[i]) begin
          valid_q[i] <= 1'b1;
        end
      end
    end
  end

  // No two valid lines ever hold the same tag
  hit_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_o));

  // A line is never claimed while its own refill returns
  strb_disjoint_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (evict_strb_i & validate_strb_i) == '0);

endmodule

//--- src/rv_fetch_pkg.sv
// RISC-V instruction formats seen by the fetch predecoder
// Opcodes and the two immediate layouts of branches and jumps

package rv_fetch_pkg;

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // Conditional branch layout
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } sb_fmt_t;

  // Jump-and-link layout
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } uj_fmt_t;

  // One instruction word, read either way
  typedef union packed {
    sb_fmt_t sb;
    uj_fmt_t uj;
  } instr_u;

  // Sign-extended branch offset
  function automatic logic [31:0] sb_imm(instr_u ins);
    return {{19{ins.sb.imm12}}, ins.sb.imm12, ins.sb.imm11,
            ins.sb.imm10_5, ins.sb.imm4_1, 1'b0};
  endfunction

  // Sign-extended jump offset
  function automatic logic [31:0] uj_imm(instr_u ins);
    return {{11{ins.uj.imm20}}, ins.uj.imm20, ins.uj.imm19_12,
            ins.uj.imm11, ins.uj.imm10_1, 1'b0};
  endfunction

endpackage

//--- src/l0_cfg_pkg.sv
// Level-0 instruction cache geometry
// Address, fetch word and line sizes shared by the cache blocks

package l0_cfg_pkg;

  // --------------------------------------------------------------------------
  // Address and data widths
  // --------------------------------------------------------------------------

  // Fetch address width in bits
  localparam int unsigned ADDR_W = 32;

  // Width of one fetched instruction word
  localparam int unsigned FETCH_W = 32;

  // Width of one cache line as delivered by the backing memory
  localparam int unsigned LINE_W = 128;

  // --------------------------------------------------------------------------
  // Organisation
  // --------------------------------------------------------------------------

  // Number of fully associative lines
  localparam int unsigned LINE_COUNT = 4;

  // Byte offset bits inside one line
  localparam int unsigned LINE_ALIGN = 4;

  // Tag covers everything above the line offset
  localparam int unsigned TAG_W = ADDR_W - LINE_ALIGN;

  // Instruction slots per line
  localparam int unsigned FETCH_PKTS = LINE_W / FETCH_W;

  // Width of a line index, used by the replacement pointer
  localparam int unsigned IDX_W = $clog2(LINE_COUNT);

endpackage
